// ==== logic/cpu_cache_pkg.sv ====
`default_nettype none

package cpu_cache_pkg;

    parameter int ADDR_WIDTH  = 32;
    parameter int WORD_WIDTH  = 32;
    parameter int LINE_WIDTH  = 128;
    parameter int LINE_WORDS  = 4;
    parameter int OFFSET_BITS = 4;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Access width of a CPU load or store.
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } access_mode_t;

    // One cache line as seen by the word path and by the byte-merge path.
    typedef union packed {
        word_t [LINE_WORDS-1:0]       words;
        logic [LINE_WIDTH/8-1:0][7:0] bytes;
    } cache_line_t;

endpackage

`default_nettype wire

// ==== logic/cache_tag_store.sv ====
`default_nettype none

module cache_tag_store #(
    parameter int NUM_SETS = 16
) (
    input  wire                     clock,
    input  wire                     rst,
    input  wire  [INDEX_BITS-1:0]   index,
    input  wire  [TAG_BITS-1:0]     tag,
    input  wire                     tag_write,
    input  wire                     set_valid,
    input  wire                     set_dirty,
    output logic                    tag_match,
    output logic                    victim_dirty,
    output logic [TAG_BITS-1:0]     victim_tag
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = cpu_cache_pkg::ADDR_WIDTH - INDEX_BITS
                                - cpu_cache_pkg::OFFSET_BITS;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_BITS-1:0] tag_q [NUM_SETS];

    // Per-set state bits.
    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (tag_write) begin
            valid_q[index] <= set_valid;
            dirty_q[index] <= set_dirty;
        end
    end

    always_ff @(posedge clock) begin
        if (tag_write) begin
            tag_q[index] <= tag; // A write hit rewrites the same tag.
        end
    end

    assign tag_match    = valid_q[index] && (tag_q[index] == tag);
    assign victim_dirty = valid_q[index] && dirty_q[index]; // Only a valid line can need write-back.
    assign victim_tag   = tag_q[index];

    // A set marked dirty must hold a valid line on the following cycle.
    dirty_implies_valid: assert property (
        @(posedge clock) disable iff (rst)
        (tag_write && set_dirty) |=> valid_q[$past(index)]
    );

endmodule

`default_nettype wire

// ==== logic/cache_data_store.sv ====
`default_nettype none

module cache_data_store #(
    parameter int NUM_SETS = 16
) (
    input  wire                                clock,
    input  wire  [INDEX_BITS-1:0]              index,
    input  wire  [cpu_cache_pkg::OFFSET_BITS-1:0] offset,
    input  wire  cpu_cache_pkg::access_mode_t  mode,
    input  wire                                fill,
    input  wire  cpu_cache_pkg::cache_line_t   fill_line,
    input  wire                                store,
    input  wire  cpu_cache_pkg::word_t         wdata,
    output cpu_cache_pkg::cache_line_t         line,
    output cpu_cache_pkg::word_t               load_word
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int OB         = cpu_cache_pkg::OFFSET_BITS;

    cpu_cache_pkg::cache_line_t lines [NUM_SETS];
    cpu_cache_pkg::cache_line_t merged;

    logic [OB-1:0] half_base;
    logic [OB-1:0] word_base;
    logic [OB-1:0] store_base;
    logic [2:0]    store_bytes;

    assign line = lines[index];

    // Aligned start bytes. Misaligned accesses are undefined.
    assign half_base = {offset[OB-1:1], 1'b0};
    assign word_base = {offset[OB-1:2], 2'b00};

    // Loads are zero extended.
    always_comb begin
        case (mode)
            cpu_cache_pkg::BYTE: begin
                load_word = cpu_cache_pkg::word_t'(line.bytes[offset]);
            end
            cpu_cache_pkg::HALF: begin
                load_word = cpu_cache_pkg::word_t'({line.bytes[half_base + OB'(1)],
                                                    line.bytes[half_base]});
            end
            default: begin
                load_word = line.words[offset[OB-1:2]];
            end
        endcase
    end

    always_comb begin
        case (mode)
            cpu_cache_pkg::BYTE: begin
                store_base  = offset;
                store_bytes = 3'd1;
            end
            cpu_cache_pkg::HALF: begin
                store_base  = half_base;
                store_bytes = 3'd2;
            end
            default: begin
                store_base  = word_base;
                store_bytes = 3'd4;
            end
        endcase
    end

    // The low bytes of wdata land on consecutive bytes from the aligned base.
    always_comb begin
        merged = line;
        for (int i = 0; i < 4; i++) begin
            if (3'(i) < store_bytes) begin
                merged.bytes[store_base + OB'(i)] = wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            lines[index] <= fill_line;
        end else if (store) begin
            lines[index] <= merged;
        end
    end

    // The controller never fills and stores in the same cycle.
    fill_store_exclusive: assert property (
        @(posedge clock) !(fill && store)
    );

endmodule

`default_nettype wire

// ==== logic/cache_controller.sv ====
`default_nettype none

module cache_controller #(
    parameter int NUM_SETS = 16
) (
    input  wire                                clock,
    input  wire                                rst,
    input  wire                                read,
    input  wire                                write,
    input  wire  cpu_cache_pkg::addr_t         addr,
    input  wire                                tag_match,
    input  wire                                victim_dirty,
    input  wire  [TAG_BITS-1:0]                victim_tag,
    input  wire  cpu_cache_pkg::cache_line_t   line,
    input  wire  cpu_cache_pkg::word_t         load_word,
    input  wire                                mem_bus_available,
    input  wire                                bus_valid,
    input  wire  cpu_cache_pkg::addr_t         bus_raddr,
    input  wire  cpu_cache_pkg::cache_line_t   bus_rdata,
    output logic [INDEX_BITS-1:0]              index,
    output logic [TAG_BITS-1:0]                tag,
    output logic                               tag_write,
    output logic                               set_valid,
    output logic                               set_dirty,
    output logic                               fill,
    output cpu_cache_pkg::cache_line_t         fill_line,
    output logic                               store,
    output logic                               hit,
    output cpu_cache_pkg::word_t               rdata,
    output logic                               bus_read,
    output logic                               bus_write,
    output cpu_cache_pkg::addr_t               bus_addr,
    output cpu_cache_pkg::cache_line_t         bus_wdata
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int OB         = cpu_cache_pkg::OFFSET_BITS;
    localparam int TAG_BITS   = cpu_cache_pkg::ADDR_WIDTH - INDEX_BITS - OB;

    localparam logic [1:0] S_LOOKUP    = 2'd0;
    localparam logic [1:0] S_WRITEBACK = 2'd1;
    localparam logic [1:0] S_FILL_REQ  = 2'd2;
    localparam logic [1:0] S_FILL_WAIT = 2'd3;

    logic [1:0]           state_q;
    logic [1:0]           state_d;
    logic                 request;
    logic                 lookup_hit;
    logic                 lookup_miss;
    logic                 fill_ok;
    logic                 wb_phase;
    cpu_cache_pkg::addr_t line_addr;
    cpu_cache_pkg::addr_t victim_addr;

    assign index = addr[OB +: INDEX_BITS];
    assign tag   = addr[cpu_cache_pkg::ADDR_WIDTH-1 -: TAG_BITS];

    assign line_addr   = {addr[cpu_cache_pkg::ADDR_WIDTH-1:OB], {OB{1'b0}}};
    assign victim_addr = {victim_tag, index, {OB{1'b0}}};

    // A request is ignored in the cycle its hit is reported.
    assign request     = (read || write) && !hit;
    assign lookup_hit  = (state_q == S_LOOKUP) && request && tag_match;
    assign lookup_miss = (state_q == S_LOOKUP) && request && !tag_match;

    assign fill_ok = (state_q == S_FILL_WAIT) && bus_valid && (bus_raddr == line_addr);

    assign store     = lookup_hit && write;
    assign fill      = fill_ok;
    assign fill_line = bus_rdata;
    assign tag_write = store || fill_ok;
    assign set_valid = store || fill_ok;
    assign set_dirty = store; // A fresh fill is clean.

    assign wb_phase  = (state_q == S_WRITEBACK) || ((state_q == S_LOOKUP) && victim_dirty);
    assign bus_addr  = wb_phase ? victim_addr : line_addr;
    assign bus_wdata = line; // The victim line is read at the request index.

    always_comb begin
        state_d   = state_q;
        bus_read  = 1'b0;
        bus_write = 1'b0;
        case (state_q)
            S_LOOKUP: begin
                if (lookup_miss && victim_dirty) begin
                    bus_write = mem_bus_available;
                    state_d   = mem_bus_available ? S_FILL_REQ : S_WRITEBACK;
                end else if (lookup_miss) begin
                    bus_read = mem_bus_available;
                    state_d  = mem_bus_available ? S_FILL_WAIT : S_FILL_REQ;
                end
            end
            S_WRITEBACK: begin
                if (mem_bus_available) begin
                    bus_write = 1'b1;
                    state_d   = S_FILL_REQ;
                end
            end
            S_FILL_REQ: begin
                if (mem_bus_available) begin
                    bus_read = 1'b1;
                    state_d  = S_FILL_WAIT;
                end
            end
            default: begin
                if (fill_ok) begin
                    state_d = S_LOOKUP; // The access is looked up again as a hit.
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= S_LOOKUP;
            hit     <= 1'b0;
        end else begin
            state_q <= state_d;
            hit     <= lookup_hit;
        end
    end

    always_ff @(posedge clock) begin
        if (lookup_hit && read) begin
            rdata <= load_word;
        end
    end

    // The write-back and fill addresses come from the request, so it must stay put.
    request_held_during_miss: assert property (
        @(posedge clock) disable iff (rst)
        (state_q != S_LOOKUP) |-> ((read || write) && $stable(addr))
    );

endmodule

`default_nettype wire

// ==== logic/cpu_cache.sv ====
`default_nettype none

module cpu_cache #(
    parameter int NUM_SETS = 16
) (
    input  wire                                clock,
    input  wire                                rst,
    input  wire                                read,
    input  wire                                write,
    input  wire  cpu_cache_pkg::addr_t         addr,
    input  wire  cpu_cache_pkg::access_mode_t  mode,
    input  wire  cpu_cache_pkg::word_t         wdata,
    output logic                               hit,
    output cpu_cache_pkg::word_t               rdata,
    input  wire                                mem_bus_available,
    output logic                               bus_read,
    output logic                               bus_write,
    output cpu_cache_pkg::addr_t               bus_addr,
    output cpu_cache_pkg::cache_line_t         bus_wdata,
    input  wire                                bus_valid,
    input  wire  cpu_cache_pkg::addr_t         bus_raddr,
    input  wire  cpu_cache_pkg::cache_line_t   bus_rdata
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int OB         = cpu_cache_pkg::OFFSET_BITS;
    localparam int TAG_BITS   = cpu_cache_pkg::ADDR_WIDTH - INDEX_BITS - OB;

    logic [INDEX_BITS-1:0]      index;
    logic [TAG_BITS-1:0]        tag;
    logic [TAG_BITS-1:0]        victim_tag;
    logic                       tag_write;
    logic                       set_valid;
    logic                       set_dirty;
    logic                       tag_match;
    logic                       victim_dirty;
    logic                       fill;
    logic                       store;
    cpu_cache_pkg::cache_line_t fill_line;
    cpu_cache_pkg::cache_line_t line;
    cpu_cache_pkg::word_t       load_word;

    cache_tag_store #(
        .NUM_SETS (NUM_SETS)
    ) u_tag_store (
        .clock        (clock),
        .rst          (rst),
        .index        (index),
        .tag          (tag),
        .tag_write    (tag_write),
        .set_valid    (set_valid),
        .set_dirty    (set_dirty),
        .tag_match    (tag_match),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_store #(
        .NUM_SETS (NUM_SETS)
    ) u_data_store (
        .clock     (clock),
        .index     (index),
        .offset    (addr[OB-1:0]),
        .mode      (mode),
        .fill      (fill),
        .fill_line (fill_line),
        .store     (store),
        .wdata     (wdata),
        .line      (line),
        .load_word (load_word)
    );

    cache_controller #(
        .NUM_SETS (NUM_SETS)
    ) u_controller (
        .clock             (clock),
        .rst               (rst),
        .read              (read),
        .write             (write),
        .addr              (addr),
        .tag_match         (tag_match),
        .victim_dirty      (victim_dirty),
        .victim_tag        (victim_tag),
        .line              (line),
        .load_word         (load_word),
        .mem_bus_available (mem_bus_available),
        .bus_valid         (bus_valid),
        .bus_raddr         (bus_raddr),
        .bus_rdata         (bus_rdata),
        .index             (index),
        .tag               (tag),
        .tag_write         (tag_write),
        .set_valid         (set_valid),
        .set_dirty         (set_dirty),
        .fill              (fill),
        .fill_line         (fill_line),
        .store             (store),
        .hit               (hit),
        .rdata             (rdata),
        .bus_read          (bus_read),
        .bus_write         (bus_write),
        .bus_addr          (bus_addr),
        .bus_wdata         (bus_wdata)
    );

endmodule

`default_nettype wire

// ==== tests/cpu_cache_tb.sv ====
`default_nettype none

module cpu_cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SETS = 16;
    localparam int TIMEOUT  = 200;

    logic                        clock;
    logic                        rst;
    logic                        read;
    logic                        write;
    cpu_cache_pkg::addr_t        addr;
    cpu_cache_pkg::access_mode_t mode;
    cpu_cache_pkg::word_t        wdata;
    logic                        hit;
    cpu_cache_pkg::word_t        rdata;
    logic                        mem_bus_available;
    logic                        bus_read;
    logic                        bus_write;
    cpu_cache_pkg::addr_t        bus_addr;
    cpu_cache_pkg::cache_line_t  bus_wdata;
    logic                        bus_valid;
    cpu_cache_pkg::addr_t        bus_raddr;
    cpu_cache_pkg::cache_line_t  bus_rdata;

    cpu_cache_pkg::cache_line_t mem [cpu_cache_pkg::addr_t];
    cpu_cache_pkg::cache_line_t shadow [cpu_cache_pkg::addr_t]; // Expected content of each line.
    cpu_cache_pkg::addr_t       resident [NUM_SETS];
    logic [NUM_SETS-1:0]        resident_valid;
    logic [NUM_SETS-1:0]        resident_dirty;
    cpu_cache_pkg::addr_t       cur_line;
    cpu_cache_pkg::addr_t       cur_victim;
    cpu_cache_pkg::addr_t       pending_addr;
    logic                       pending;
    int                         delay;
    int                         read_count;
    int                         write_count;

    cpu_cache #(.NUM_SETS(NUM_SETS)) u_cpu_cache (
        .clock(clock), .rst(rst), .read(read), .write(write), .addr(addr), .mode(mode),
        .wdata(wdata), .hit(hit), .rdata(rdata), .mem_bus_available(mem_bus_available),
        .bus_read(bus_read), .bus_write(bus_write), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_valid(bus_valid), .bus_raddr(bus_raddr),
        .bus_rdata(bus_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
            fail_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, act, exp));
    endtask

    task automatic check_word(input string name, input cpu_cache_pkg::word_t act,
                              input cpu_cache_pkg::word_t exp);
        if (act !== exp)
            fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, act, exp));
    endtask

    task automatic check_addr(input string name, input cpu_cache_pkg::addr_t act,
                              input cpu_cache_pkg::addr_t exp);
        if (act !== exp)
            fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, act, exp));
    endtask

    task automatic check_line(input string name, input cpu_cache_pkg::cache_line_t act,
                              input cpu_cache_pkg::cache_line_t exp);
        if (act !== exp)
            fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, act, exp));
    endtask

    task automatic check_count(input string name, input int act, input int exp);
        if (act != exp)
            fail_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, act, exp));
    endtask

    // Untouched memory holds each word's byte address XOR a fixed pattern.
    function automatic cpu_cache_pkg::cache_line_t initial_line(cpu_cache_pkg::addr_t la);
        cpu_cache_pkg::cache_line_t l;
        for (int i = 0; i < cpu_cache_pkg::LINE_WORDS; i++) begin
            l.words[i] = (la + 4 * i) ^ 32'hA5A5A5A5;
        end
        return l;
    endfunction

    function automatic cpu_cache_pkg::cache_line_t memory_line(cpu_cache_pkg::addr_t la);
        return mem.exists(la) ? mem[la] : initial_line(la);
    endfunction

    function automatic cpu_cache_pkg::cache_line_t reference_line(cpu_cache_pkg::addr_t la);
        return shadow.exists(la) ? shadow[la] : initial_line(la);
    endfunction

    task automatic apply_store(input cpu_cache_pkg::addr_t a,
                               input cpu_cache_pkg::access_mode_t m,
                               input cpu_cache_pkg::word_t d);
        cpu_cache_pkg::cache_line_t l;
        int                         base;
        int                         n;
        l = reference_line(a & ~32'hF);
        case (m)
            cpu_cache_pkg::BYTE: begin
                base = a[3:0];
                n    = 1;
            end
            cpu_cache_pkg::HALF: begin
                base = {a[3:1], 1'b0};
                n    = 2;
            end
            default: begin
                base = {a[3:2], 2'b00};
                n    = 4;
            end
        endcase
        for (int i = 0; i < n; i++) begin
            l.bytes[base + i] = d[8*i +: 8]; // Little endian within the line.
        end
        shadow[a & ~32'hF] = l;
    endtask

    // The bus strobes are stable from the falling edge up to this edge.
    always @(posedge clock) begin
        if (!rst) begin
            if (!mem_bus_available) begin
                check_bit("bus_read", bus_read, 1'b0);
                check_bit("bus_write", bus_write, 1'b0);
            end
            if (bus_read) begin
                check_addr("bus_addr", bus_addr, cur_line);
                read_count++;
                pending      = 1'b1;
                delay        = 3;
                pending_addr = bus_addr;
            end
            if (bus_write) begin
                check_addr("bus_addr", bus_addr, cur_victim);
                check_line("bus_wdata", bus_wdata, reference_line(bus_addr));
                mem[bus_addr] = bus_wdata;
                write_count++;
            end
        end
    end

    initial begin
        void'($urandom(68946));
        mem_bus_available = 1'b0;
        bus_valid         = 1'b0;
        bus_raddr         = '0;
        bus_rdata         = '0;
        pending           = 1'b0;
        delay             = 0;
        forever begin
            @(negedge clock);
            mem_bus_available = ($urandom % 3) != 0; // Busy about a third of the time.
            bus_valid         = 1'b0;
            if (pending && delay > 1) begin
                delay--;
            end else if (pending) begin
                bus_valid = 1'b1;
                bus_raddr = pending_addr;
                bus_rdata = memory_line(pending_addr);
                pending   = 1'b0;
            end
        end
    end

    task automatic run_access(input logic is_write, input cpu_cache_pkg::access_mode_t m,
                              input cpu_cache_pkg::addr_t a, input cpu_cache_pkg::word_t d,
                              input logic check_load, input cpu_cache_pkg::word_t exp,
                              input int line_no);
        int   idx;
        int   cycles;
        logic miss;
        idx        = int'((a >> cpu_cache_pkg::OFFSET_BITS) % NUM_SETS);
        cur_line   = a & ~32'hF;
        cur_victim = resident[idx];
        miss       = !resident_valid[idx] || (resident[idx] != cur_line);
        read_count  = 0;
        write_count = 0;
        read  = !is_write;
        write = is_write;
        addr  = a;
        mode  = m;
        wdata = d;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!hit && cycles < TIMEOUT);
        if (!hit)
            fail_run($sformatf("Timeout: the access on data line %0d never got a hit.", line_no));
        check_count("bus_read count", read_count, miss ? 1 : 0);
        check_count("bus_write count", write_count,
                    (miss && resident_valid[idx] && resident_dirty[idx]) ? 1 : 0);
        if (!is_write && check_load) check_word("rdata", rdata, exp);
        if (is_write) apply_store(a, m, d);
        if (miss) resident_dirty[idx] = 1'b0;
        if (is_write) resident_dirty[idx] = 1'b1;
        resident[idx]       = cur_line;
        resident_valid[idx] = 1'b1;
        read  = 1'b0;
        write = 1'b0;
    endtask

    initial begin
        int                          fd;
        int                          line_no;
        int                          accesses;
        string                       text;
        string                       op_s;
        string                       mode_s;
        string                       exp_s;
        cpu_cache_pkg::addr_t        a;
        cpu_cache_pkg::word_t        wd;
        cpu_cache_pkg::word_t        exp;
        cpu_cache_pkg::access_mode_t m;
        rst = 1'b1;
        read = 1'b0;
        write = 1'b0;
        addr = '0;
        mode = cpu_cache_pkg::WORD;
        wdata = '0;
        cur_line = '0;
        cur_victim = '0;
        resident_valid = '0;
        resident_dirty = '0;
        for (int i = 0; i < 6; i++) begin
            @(negedge clock);
            if (i == 4) rst = 1'b0; // Five rising edges see reset and the sixth is free.
            check_bit("hit", hit, 1'b0);
            check_bit("bus_read", bus_read, 1'b0);
            check_bit("bus_write", bus_write, 1'b0);
        end
        fd = $fopen("tests/cpu_cache_tests.txt", "r");
        if (fd == 0) fail_run("Could not open tests/cpu_cache_tests.txt.");
        line_no  = 0;
        accesses = 0;
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            line_no++;
            if (text.len() < 3 || text[0] == "#") continue;
            if ($sscanf(text, "%s %s %h %h %s", op_s, mode_s, a, wd, exp_s) != 5)
                fail_run($sformatf("Data line %0d is malformed.", line_no));
            case (mode_s)
                "B":     m = cpu_cache_pkg::BYTE;
                "H":     m = cpu_cache_pkg::HALF;
                "W":     m = cpu_cache_pkg::WORD;
                default: fail_run($sformatf("Data line %0d has an unknown mode.", line_no));
            endcase
            if (op_s != "R" && op_s != "W")
                fail_run($sformatf("Data line %0d has an unknown operation.", line_no));
            exp = '0;
            if (exp_s != "-") void'($sscanf(exp_s, "%h", exp));
            run_access(op_s == "W", m, a, wd, exp_s != "-", exp, line_no);
            accesses++;
        end
        $fclose(fd);
        if (accesses == 0) begin
            fail_run("The test data file holds no accesses.");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/cpu_cache_pkg.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_controller.sv
logic/cpu_cache.sv
tests/cpu_cache_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_cache

sources:
  - files:
      - logic/cpu_cache_pkg.sv
      - logic/cache_tag_store.sv
      - logic/cache_data_store.sv
      - logic/cache_controller.sv
      - logic/cpu_cache.sv
  - target: test
    files:
      - tests/cpu_cache_tb.sv

// ==== tests/cpu_cache_tests.txt ====
# op (R or W), mode (B, H or W), byte address in hex, write data in hex,
# expected load data in hex, or - where nothing is checked
R W 00000100 00000000 A5A5A4A5
R W 00000108 00000000 A5A5A4AD
R B 0000010D 00000000 000000A4
R H 00000104 00000000 0000A4A1
W W 00000104 11223344 -
W B 00000104 00000055 -
W B 00000105 00000066 -
R W 00000104 00000000 11226655
W H 0000010A 0000BEEF -
R W 00000108 00000000 BEEFA4AD
R H 0000010A 00000000 0000BEEF
R B 00000107 00000000 00000011
W W 0000010C CAFEF00D -
R B 0000010E 00000000 000000FE
# Same set, new tag, so the dirty line at 00000100 goes back to memory.
R W 00000200 00000000 A5A5A7A5
R W 0000020C 00000000 A5A5A7A9
W W 00000200 12345678 -
R W 00000104 00000000 11226655
R W 0000010C 00000000 CAFEF00D
R W 00000108 00000000 BEEFA4AD
R W 00000200 00000000 12345678
R B 00000201 00000000 00000056
W B 000001F3 0000007E -
R W 000001F0 00000000 7EA5A455
R H 000001F2 00000000 00007EA5
R W ABCD00F4 00000000 0E68A551
W W ABCD00F8 DEADBEEF -
R H ABCD00F8 00000000 0000BEEF
R W 000001F0 00000000 7EA5A455
R W 00000110 00000000 A5A5A4B5
W H 00000112 00001234 -
R W 00000110 00000000 1234A4B5
R W ABCD00F8 00000000 DEADBEEF
R B ABCD00F9 00000000 000000BE
